/* design/mem_stage_params.svh */
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// Data, address and pc width.
`define XLEN 64

// Fetch start address, loaded into the pc field on reset.
`define RESET_PC 64'h0000_0000_3000_0000

// Data RAM depth in doublewords.
`define RAM_WORDS 512

// Doubleword address width, log2 of RAM_WORDS.
`define RAM_AW 9

`endif

/* design/mem_stage_pkg.sv */
`include "mem_stage_params.svh"

package mem_stage_pkg;

    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,
        MEM_LB  = 4'd1,
        MEM_LH  = 4'd2,
        MEM_LW  = 4'd3,
        MEM_LD  = 4'd4,
        MEM_LBU = 4'd5,
        MEM_LHU = 4'd6,
        MEM_LWU = 4'd7,
        MEM_SB  = 4'd8,
        MEM_SH  = 4'd9,
        MEM_SW  = 4'd10,
        MEM_SD  = 4'd11
    } mem_ctrl_e;

    typedef enum logic [3:0] {
        WB_NOP = 4'd0, // No register write.
        WB_ALU = 4'd1,
        WB_MEM = 4'd2
    } wb_ctrl_e;

    typedef enum logic [3:0] {
        TRAP_NOP            = 4'd0,
        TRAP_ILLEGAL        = 4'd1,
        TRAP_LOAD_MISALIGN  = 4'd2,
        TRAP_STORE_MISALIGN = 4'd3
    } trap_e;

    // One bus word, whole or by byte lane.
    typedef union packed {
        logic [`XLEN-1:0] dword;
        logic [7:0][7:0]  lanes;
    } mem_word_u;

endpackage

/* design/ex_mem_reg.sv */
`include "mem_stage_params.svh"

module ex_mem_reg (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,

    input  logic                     valid_in,
    input  mem_stage_pkg::trap_e     trap_in,
    input  logic [`XLEN-1:0]         result_in,
    input  logic [`XLEN-1:0]         store_data_in,
    input  logic [4:0]               rd_in,
    input  logic [`XLEN-1:0]         pc_in,
    input  mem_stage_pkg::mem_ctrl_e mem_ctrl_in,
    input  mem_stage_pkg::wb_ctrl_e  wb_ctrl_in,

    output logic                     valid_out,
    output mem_stage_pkg::trap_e     trap_out,
    output logic [`XLEN-1:0]         result_out,
    output logic [`XLEN-1:0]         store_data_out,
    output logic [4:0]               rd_out,
    output logic [`XLEN-1:0]         pc_out,
    output mem_stage_pkg::mem_ctrl_e mem_ctrl_out,
    output mem_stage_pkg::wb_ctrl_e  wb_ctrl_out
);

    // Reset leaves a bubble at the fetch start pc.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_out      <= 1'b0;
            trap_out       <= mem_stage_pkg::TRAP_NOP;
            result_out     <= '0;
            store_data_out <= '0;
            rd_out         <= 5'd0;
            pc_out         <= `RESET_PC;
            mem_ctrl_out   <= mem_stage_pkg::MEM_NOP;
            wb_ctrl_out    <= mem_stage_pkg::WB_NOP;
        end else if (enable) begin
            valid_out      <= valid_in;
            trap_out       <= trap_in;
            result_out     <= result_in;
            store_data_out <= store_data_in;
            rd_out         <= rd_in;
            pc_out         <= pc_in;
            mem_ctrl_out   <= mem_ctrl_in;
            wb_ctrl_out    <= wb_ctrl_in;
        end
        // Enable low holds every field.
    end

endmodule

/* design/load_store_unit.sv */
`include "mem_stage_params.svh"

module load_store_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid,
    input  mem_stage_pkg::trap_e     trap,
    input  logic [`XLEN-1:0]         addr,
    input  logic [`XLEN-1:0]         store_data,
    input  logic [4:0]               rd,
    input  logic [`XLEN-1:0]         pc,
    input  mem_stage_pkg::mem_ctrl_e mem_ctrl,
    input  mem_stage_pkg::wb_ctrl_e  wb_ctrl,
    output logic                     busy,

    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [`RAM_AW-1:0]       wb_adr,
    output logic [7:0]               wb_sel,
    output mem_stage_pkg::mem_word_u wb_dat_w,
    input  mem_stage_pkg::mem_word_u wb_dat_r,
    input  logic                     wb_ack,

    output logic                     rf_valid,
    output logic                     rf_we,
    output logic [4:0]               rf_rd,
    output logic [`XLEN-1:0]         rf_data,
    output logic [`XLEN-1:0]         rf_pc,
    output mem_stage_pkg::trap_e     rf_trap
);

    logic [2:0]           off;
    logic [2:0]           align_mask;
    logic [7:0]           size_sel;
    logic                 is_store;
    logic                 misaligned;
    logic                 mem_req;
    mem_stage_pkg::trap_e final_trap;
    logic [7:0]           lane_b;
    logic [15:0]          lane_h;
    logic [31:0]          lane_w;
    logic [`XLEN-1:0]     load_data;

    assign off = addr[2:0];

    // Access size and direction.
    always_comb begin
        align_mask = 3'b000;
        size_sel   = 8'h01;
        is_store   = 1'b0;
        case (mem_ctrl)
            mem_stage_pkg::MEM_LH, mem_stage_pkg::MEM_LHU: begin
                align_mask = 3'b001;
                size_sel   = 8'h03;
            end
            mem_stage_pkg::MEM_LW, mem_stage_pkg::MEM_LWU: begin
                align_mask = 3'b011;
                size_sel   = 8'h0f;
            end
            mem_stage_pkg::MEM_LD: begin
                align_mask = 3'b111;
                size_sel   = 8'hff;
            end
            mem_stage_pkg::MEM_SB: is_store = 1'b1;
            mem_stage_pkg::MEM_SH: begin
                align_mask = 3'b001;
                size_sel   = 8'h03;
                is_store   = 1'b1;
            end
            mem_stage_pkg::MEM_SW: begin
                align_mask = 3'b011;
                size_sel   = 8'h0f;
                is_store   = 1'b1;
            end
            mem_stage_pkg::MEM_SD: begin
                align_mask = 3'b111;
                size_sel   = 8'hff;
                is_store   = 1'b1;
            end
            default: ;
        endcase
    end

    assign misaligned = |(off & align_mask);

    // An incoming trap wins over misalignment.
    always_comb begin
        if (trap != mem_stage_pkg::TRAP_NOP)
            final_trap = trap;
        else if (misaligned && is_store)
            final_trap = mem_stage_pkg::TRAP_STORE_MISALIGN;
        else if (misaligned)
            final_trap = mem_stage_pkg::TRAP_LOAD_MISALIGN;
        else
            final_trap = mem_stage_pkg::TRAP_NOP;
    end

    assign mem_req = valid && (final_trap == mem_stage_pkg::TRAP_NOP)
                     && (mem_ctrl != mem_stage_pkg::MEM_NOP);
    assign busy    = mem_req & ~wb_ack; // Drops in the ack cycle.

    assign wb_cyc = mem_req;
    assign wb_stb = mem_req;
    assign wb_we  = is_store;
    assign wb_adr = addr[`RAM_AW+2:3];
    assign wb_sel = size_sel << off;

    // Store data goes out on every lane of its size.
    always_comb begin
        case (mem_ctrl)
            mem_stage_pkg::MEM_SB: wb_dat_w.dword = {8{store_data[7:0]}};
            mem_stage_pkg::MEM_SH: wb_dat_w.dword = {4{store_data[15:0]}};
            mem_stage_pkg::MEM_SW: wb_dat_w.dword = {2{store_data[31:0]}};
            default:               wb_dat_w.dword = store_data;
        endcase
    end

    assign lane_b = wb_dat_r.lanes[off];
    assign lane_h = {wb_dat_r.lanes[{off[2:1], 1'b1}], wb_dat_r.lanes[{off[2:1], 1'b0}]};
    assign lane_w = {wb_dat_r.lanes[{off[2], 2'd3}], wb_dat_r.lanes[{off[2], 2'd2}],
                     wb_dat_r.lanes[{off[2], 2'd1}], wb_dat_r.lanes[{off[2], 2'd0}]};

    always_comb begin
        case (mem_ctrl)
            mem_stage_pkg::MEM_LB:  load_data = {{(`XLEN-8){lane_b[7]}}, lane_b};
            mem_stage_pkg::MEM_LBU: load_data = {{(`XLEN-8){1'b0}}, lane_b};
            mem_stage_pkg::MEM_LH:  load_data = {{(`XLEN-16){lane_h[15]}}, lane_h};
            mem_stage_pkg::MEM_LHU: load_data = {{(`XLEN-16){1'b0}}, lane_h};
            mem_stage_pkg::MEM_LW:  load_data = {{(`XLEN-32){lane_w[31]}}, lane_w};
            mem_stage_pkg::MEM_LWU: load_data = {{(`XLEN-32){1'b0}}, lane_w};
            mem_stage_pkg::MEM_LD:  load_data = wb_dat_r.dword;
            default:                load_data = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rf_valid <= 1'b0;
            rf_we    <= 1'b0;
        end else begin
            rf_valid <= valid & ~busy;
            rf_we    <= valid && !busy && (final_trap == mem_stage_pkg::TRAP_NOP)
                        && (wb_ctrl != mem_stage_pkg::WB_NOP) && (rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            rf_rd   <= rd;
            rf_pc   <= pc;
            rf_trap <= final_trap;
            if (mem_req && wb_ctrl == mem_stage_pkg::WB_MEM)
                rf_data <= load_data;
            else
                rf_data <= addr; // Execute result.
        end
    end

endmodule

/* design/data_ram_wb.sv */
`include "mem_stage_params.svh"

module data_ram_wb (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`RAM_AW-1:0]       wb_adr,
    input  logic [7:0]               wb_sel,
    input  mem_stage_pkg::mem_word_u wb_dat_w,
    output mem_stage_pkg::mem_word_u wb_dat_r,
    output logic                     wb_ack
);

    mem_stage_pkg::mem_word_u mem [`RAM_WORDS] = '{default: '0};
    logic                     access;

    // First cycle of a strobe. The ack cycle itself never starts another.
    assign access = wb_cyc & wb_stb & ~wb_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wb_ack <= 1'b0;
        else
            wb_ack <= access;
    end

    // Write or read on the edge that raises ack.
    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_we) begin
                for (int b = 0; b < 8; b++) begin
                    if (wb_sel[b])
                        mem[wb_adr].lanes[b] <= wb_dat_w.lanes[b];
                end
            end else begin
                wb_dat_r <= mem[wb_adr];
            end
        end
    end

endmodule

/* design/mem_stage_top.sv */
`include "mem_stage_params.svh"

module mem_stage_top (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     ex_valid,
    input  mem_stage_pkg::trap_e     ex_trap,
    input  logic [`XLEN-1:0]         ex_result,
    input  logic [`XLEN-1:0]         ex_store_data,
    input  logic [4:0]               ex_rd,
    input  logic [`XLEN-1:0]         ex_pc,
    input  mem_stage_pkg::mem_ctrl_e ex_mem_ctrl,
    input  mem_stage_pkg::wb_ctrl_e  ex_wb_ctrl,
    output logic                     ex_ready,

    output logic                     rf_valid,
    output logic                     rf_we,
    output logic [4:0]               rf_rd,
    output logic [`XLEN-1:0]         rf_data,
    output logic [`XLEN-1:0]         rf_pc,
    output mem_stage_pkg::trap_e     rf_trap
);

    logic                     mem_valid;
    mem_stage_pkg::trap_e     mem_trap;
    logic [`XLEN-1:0]         mem_result;
    logic [`XLEN-1:0]         mem_store_data;
    logic [4:0]               mem_rd;
    logic [`XLEN-1:0]         mem_pc;
    mem_stage_pkg::mem_ctrl_e mem_mem_ctrl;
    mem_stage_pkg::wb_ctrl_e  mem_wb_ctrl;
    logic                     busy;

    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`RAM_AW-1:0]       wb_adr;
    logic [7:0]               wb_sel;
    mem_stage_pkg::mem_word_u wb_dat_w;
    mem_stage_pkg::mem_word_u wb_dat_r;
    logic                     wb_ack;

    assign ex_ready = ~busy; // Also the register enable.

    ex_mem_reg u_ex_mem_reg (
        .clk(clk), .rst(rst), .enable(ex_ready),
        .valid_in(ex_valid), .trap_in(ex_trap), .result_in(ex_result),
        .store_data_in(ex_store_data), .rd_in(ex_rd), .pc_in(ex_pc),
        .mem_ctrl_in(ex_mem_ctrl), .wb_ctrl_in(ex_wb_ctrl),
        .valid_out(mem_valid), .trap_out(mem_trap), .result_out(mem_result),
        .store_data_out(mem_store_data), .rd_out(mem_rd), .pc_out(mem_pc),
        .mem_ctrl_out(mem_mem_ctrl), .wb_ctrl_out(mem_wb_ctrl)
    );

    load_store_unit u_lsu (
        .clk(clk), .rst(rst), .valid(mem_valid), .trap(mem_trap), .addr(mem_result),
        .store_data(mem_store_data), .rd(mem_rd), .pc(mem_pc),
        .mem_ctrl(mem_mem_ctrl), .wb_ctrl(mem_wb_ctrl), .busy(busy),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .rf_valid(rf_valid), .rf_we(rf_we), .rf_rd(rf_rd), .rf_data(rf_data),
        .rf_pc(rf_pc), .rf_trap(rf_trap)
    );

    data_ram_wb u_ram (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

endmodule

/* testbench/mem_stage_asserts.sv */
`include "mem_stage_params.svh"

module mem_stage_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 wb_cyc,
    input logic                 wb_stb,
    input logic                 wb_we,
    input logic [`RAM_AW-1:0]   wb_adr,
    input logic [7:0]           wb_sel,
    input logic [`XLEN-1:0]     wb_dat_w,
    input logic                 wb_ack,
    input logic                 ex_ready,
    input logic                 mem_valid,
    input mem_stage_pkg::trap_e mem_trap,
    input logic [`XLEN-1:0]     mem_pc
);
    timeunit 1ns;
    timeprecision 100ps;

    // Request stays put until the slave answers.
    held_until_ack: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we)
                              && $stable(wb_sel) && $stable(wb_dat_w))
        else $error("Wishbone request changed before ack");

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack held for more than one cycle");

    ack_needs_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> wb_cyc && wb_stb)
        else $error("wb_ack without an open bus cycle");

    // The stall must also freeze the EX/MEM register.
    stall_while_busy: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !wb_ack |-> !ex_ready ##1 $stable(mem_valid) && $stable(mem_pc))
        else $error("ex_ready high or register moved during an unanswered bus cycle");

    no_cycle_on_trap: assert property (@(posedge clk) disable iff (rst)
        mem_valid && mem_trap != mem_stage_pkg::TRAP_NOP |-> !wb_cyc)
        else $error("Bus cycle started for a trapped item");

endmodule

bind mem_stage_top mem_stage_asserts u_mem_stage_asserts (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack),
    .ex_ready(ex_ready), .mem_valid(mem_valid), .mem_trap(mem_trap), .mem_pc(mem_pc)
);

/* testbench/tb_mem_stage.sv */
`include "mem_stage_params.svh"

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic                 we;
        logic [4:0]           rd;
        logic [`XLEN-1:0]     data;
        logic [`XLEN-1:0]     pc;
        mem_stage_pkg::trap_e trap;
        logic [31:0]          due; // Cycle at which rf_valid must be seen.
    } expect_t;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     ex_valid;
    mem_stage_pkg::trap_e     ex_trap;
    logic [`XLEN-1:0]         ex_result;
    logic [`XLEN-1:0]         ex_store_data;
    logic [4:0]               ex_rd;
    logic [`XLEN-1:0]         ex_pc;
    mem_stage_pkg::mem_ctrl_e ex_mem_ctrl;
    mem_stage_pkg::wb_ctrl_e  ex_wb_ctrl;
    logic                     ex_ready;
    logic                     rf_valid;
    logic                     rf_we;
    logic [4:0]               rf_rd;
    logic [`XLEN-1:0]         rf_data;
    logic [`XLEN-1:0]         rf_pc;
    mem_stage_pkg::trap_e     rf_trap;

    logic [7:0]       model_mem [`RAM_WORDS*8] = '{default: 8'h00};
    expect_t          pending[$];
    logic [31:0]      cycle = 32'd0;
    logic [`XLEN-1:0] next_pc = 64'h0000_0000_8000_0000;
    integer           seed = 32'h806f6776;

    mem_stage_top u_mem_stage_top (.*);

    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic int op_size(input mem_stage_pkg::mem_ctrl_e op);
        case (op)
            mem_stage_pkg::MEM_LB, mem_stage_pkg::MEM_LBU, mem_stage_pkg::MEM_SB: return 1;
            mem_stage_pkg::MEM_LH, mem_stage_pkg::MEM_LHU, mem_stage_pkg::MEM_SH: return 2;
            mem_stage_pkg::MEM_LW, mem_stage_pkg::MEM_LWU, mem_stage_pkg::MEM_SW: return 4;
            mem_stage_pkg::MEM_LD, mem_stage_pkg::MEM_SD: return 8;
            default: return 0;
        endcase
    endfunction

    // Byte model of the RAM, updated in acceptance order.
    task automatic predict_result(input mem_stage_pkg::trap_e trap,
                                  input logic [`XLEN-1:0] result, input logic [`XLEN-1:0] store,
                                  input logic [4:0] rd, input logic [`XLEN-1:0] pc,
                                  input mem_stage_pkg::mem_ctrl_e op,
                                  input mem_stage_pkg::wb_ctrl_e wb);
        expect_t          e;
        int               size;
        logic             is_store;
        logic             access;
        logic [`XLEN-1:0] load;
        size = op_size(op);
        is_store = op >= mem_stage_pkg::MEM_SB;
        e.trap = trap;
        if (trap == mem_stage_pkg::TRAP_NOP && size != 0 && int'(result[2:0]) % size != 0)
            e.trap = is_store ? mem_stage_pkg::TRAP_STORE_MISALIGN
                              : mem_stage_pkg::TRAP_LOAD_MISALIGN;
        access = e.trap == mem_stage_pkg::TRAP_NOP && size != 0;
        load = '0;
        for (int i = size - 1; access && i >= 0; i--) begin
            if (is_store)
                model_mem[int'(result[11:0]) + i] = store[8*i +: 8];
            load = {load[55:0], model_mem[int'(result[11:0]) + i]};
        end
        if (op inside {mem_stage_pkg::MEM_LB, mem_stage_pkg::MEM_LH, mem_stage_pkg::MEM_LW}
            && load[8*size-1])
            load = load | (~64'h0 << (8 * size)); // Sign fill.
        e.we = e.trap == mem_stage_pkg::TRAP_NOP && wb != mem_stage_pkg::WB_NOP && rd != 5'd0;
        e.data = (access && wb == mem_stage_pkg::WB_MEM) ? load : result;
        e.rd = rd;
        e.pc = pc;
        e.due = cycle + (access ? 32'd3 : 32'd2);
        pending.push_back(e);
    endtask

    task automatic send(input logic valid, input mem_stage_pkg::trap_e trap,
                        input logic [`XLEN-1:0] result, input logic [`XLEN-1:0] store,
                        input logic [4:0] rd, input mem_stage_pkg::mem_ctrl_e op,
                        input mem_stage_pkg::wb_ctrl_e wb);
        int waited;
        waited = 0;
        ex_valid      <= valid;
        ex_trap       <= trap;
        ex_result     <= result;
        ex_store_data <= store;
        ex_rd         <= rd;
        ex_pc         <= next_pc;
        ex_mem_ctrl   <= op;
        ex_wb_ctrl    <= wb;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 20)
                stop_run("Timeout while waiting for ex_ready");
        end while (!ex_ready);
        if (valid)
            predict_result(trap, result, store, rd, next_pc, op, wb);
        next_pc = next_pc + 4;
    endtask

    task automatic send_random();
        int                       r;
        mem_stage_pkg::mem_ctrl_e op;
        mem_stage_pkg::wb_ctrl_e  wb;
        mem_stage_pkg::trap_e     trap;
        logic [`XLEN-1:0]         addr;
        r = $random(seed) & 32'h7fff_ffff;
        op = mem_stage_pkg::mem_ctrl_e'(4'(r % 12));
        trap = (($random(seed) & 15) == 0) ? mem_stage_pkg::TRAP_ILLEGAL
                                           : mem_stage_pkg::TRAP_NOP;
        if (op == mem_stage_pkg::MEM_NOP)
            wb = mem_stage_pkg::WB_ALU;
        else
            wb = (op >= mem_stage_pkg::MEM_SB) ? mem_stage_pkg::WB_NOP : mem_stage_pkg::WB_MEM;
        addr = 64'($random(seed) & 32'hfff);
        if (($random(seed) & 3) != 0)
            addr[2:0] = 3'd0; // Mostly aligned.
        send(($random(seed) & 7) != 0, trap, addr, {$random(seed), $random(seed)},
             5'($random(seed)), op, wb);
    endtask

    // Scoreboard on the write-back side.
    always @(posedge clk) begin
        expect_t exp_item;
        if (!rst && rf_valid) begin
            if (pending.size() == 0)
                stop_run("rf_valid rose with no item in flight");
            exp_item = pending.pop_front();
            if (cycle != exp_item.due)
                stop_run($sformatf("Item at pc %h left at the wrong cycle", exp_item.pc));
            check_field("rf_we", 64'(exp_item.we), 64'(rf_we));
            check_field("rf_rd", 64'(exp_item.rd), 64'(rf_rd));
            check_field("rf_pc", exp_item.pc, rf_pc);
            check_field("rf_trap", 64'(exp_item.trap), 64'(rf_trap));
            check_field("rf_data", exp_item.data, rf_data);
        end else if (!rst && pending.size() != 0 && cycle > pending[0].due) begin
            stop_run("rf_valid did not arrive in time");
        end
    end

    initial begin
        int waited;
        rst           = 1'b1;
        ex_valid      = 1'b0;
        ex_trap       = mem_stage_pkg::TRAP_NOP;
        ex_result     = '0;
        ex_store_data = '0;
        ex_rd         = 5'd0;
        ex_pc         = '0;
        ex_mem_ctrl   = mem_stage_pkg::MEM_NOP;
        ex_wb_ctrl    = mem_stage_pkg::WB_NOP;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_field("rf_valid", 64'(1'b0), 64'(rf_valid));
        check_field("rf_we", 64'(1'b0), 64'(rf_we));
        check_field("wb_cyc", 64'(1'b0), 64'(u_mem_stage_top.wb_cyc));
        check_field("wb_stb", 64'(1'b0), 64'(u_mem_stage_top.wb_stb));
        check_field("wb_ack", 64'(1'b0), 64'(u_mem_stage_top.wb_ack));
        check_field("ex_ready", 64'(1'b1), 64'(ex_ready));
        check_field("mem_valid", 64'(1'b0), 64'(u_mem_stage_top.mem_valid));
        check_field("mem_pc", `RESET_PC, u_mem_stage_top.mem_pc);
        send(1'b0, mem_stage_pkg::TRAP_NOP, 64'h0, 64'h0, 5'd1, mem_stage_pkg::MEM_NOP,
             mem_stage_pkg::WB_ALU);
        send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h1234_5678_9abc_def0, 64'h0, 5'd3,
             mem_stage_pkg::MEM_NOP, mem_stage_pkg::WB_ALU);
        send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h55, 64'h0, 5'd0, mem_stage_pkg::MEM_NOP,
             mem_stage_pkg::WB_ALU);
        send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h66, 64'h0, 5'd7, mem_stage_pkg::MEM_NOP,
             mem_stage_pkg::WB_NOP);
        // One store of each size, then every load kind over them.
        send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h100, 64'hf1e2_d3c4_b5a6_9788, 5'd0,
             mem_stage_pkg::MEM_SD, mem_stage_pkg::WB_NOP);
        send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h108, 64'h8000_0001, 5'd0,
             mem_stage_pkg::MEM_SW, mem_stage_pkg::WB_NOP);
        send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h10c, 64'h9abc, 5'd0,
             mem_stage_pkg::MEM_SH, mem_stage_pkg::WB_NOP);
        send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h10f, 64'hc3, 5'd0,
             mem_stage_pkg::MEM_SB, mem_stage_pkg::WB_NOP);
        for (int k = 1; k < 8; k++) begin
            send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h100, 64'h0, 5'(k),
                 mem_stage_pkg::mem_ctrl_e'(k), mem_stage_pkg::WB_MEM);
            send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h10c - (k == 4 ? 4 : 0), 64'h0, 5'(k + 8),
                 mem_stage_pkg::mem_ctrl_e'(k), mem_stage_pkg::WB_MEM);
        end
        // Misaligned accesses, then an aligned read back.
        for (int k = 9; k < 12; k++)
            send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h100 + k, 64'hffff_ffff_ffff_ffff, 5'd4,
                 mem_stage_pkg::mem_ctrl_e'(k), mem_stage_pkg::WB_NOP);
        for (int k = 2; k < 5; k++)
            send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h103 + k, 64'h0, 5'd6,
                 mem_stage_pkg::mem_ctrl_e'(k), mem_stage_pkg::WB_MEM);
        send(1'b1, mem_stage_pkg::TRAP_NOP, 64'h108, 64'h0, 5'd9, mem_stage_pkg::MEM_LD,
             mem_stage_pkg::WB_MEM);
        send(1'b1, mem_stage_pkg::TRAP_ILLEGAL, 64'h100, 64'h0, 5'd5, mem_stage_pkg::MEM_SD,
             mem_stage_pkg::WB_MEM);
        repeat (500) send_random();
        send(1'b0, mem_stage_pkg::TRAP_NOP, 64'h0, 64'h0, 5'd0, mem_stage_pkg::MEM_NOP,
             mem_stage_pkg::WB_NOP);
        waited = 0;
        while (pending.size() != 0 && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (pending.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("Timeout with %0d results still missing", pending.size());
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

/* vlog.f */
+incdir+design
design/mem_stage_pkg.sv
design/ex_mem_reg.sv
design/load_store_unit.sv
design/data_ram_wb.sv
design/mem_stage_top.sv
testbench/mem_stage_asserts.sv
testbench/tb_mem_stage.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_mem_stage
FILELIST := vlog.f
OBJ_DIR  := obj_dir

SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) design/mem_stage_params.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
